/* hw/ntt_apb_regs.sv */
`timescale 1ns/1ns
`default_nettype none

module ntt_apb_regs (
  input  wire                    clk,
  input  wire                    rst,
  input  wire                    psel,
  input  wire                    penable,
  input  wire                    pwrite,
  input  ntt_ctrl_pkg::apb_addr_t paddr,
  input  ntt_ctrl_pkg::apb_data_t pwdata,
  input  wire                    run_done,
  output ntt_ctrl_pkg::apb_data_t prdata,
  output logic                   pready,
  output logic                   pslverr,
  output logic                   launch,
  output ntt_ctrl_pkg::ntt_cmd_t  cmd,
  output logic                   busy
);

  ntt_ctrl_pkg::ntt_cmd_t cmd_q;
  ntt_ctrl_pkg::ntt_cmd_t wr_cmd;
  logic                   launch_q;
  logic                   busy_q;
  logic                   done_q;
  logic                   acc;
  logic                   sel_cmd;
  logic                   sel_status;
  logic                   start_req;
  logic                   refused;
  logic                   start_ok;
  logic                   status_rd;

  // access phase only, no wait states
  assign acc        = psel & penable;
  assign sel_cmd    = (paddr == ntt_ctrl_pkg::ADDR_CMD);
  assign sel_status = (paddr == ntt_ctrl_pkg::ADDR_STATUS);
  assign wr_cmd     = ntt_ctrl_pkg::ntt_cmd_t'(pwdata[2:0]);

  // start written to the command register
  assign start_req = acc & pwrite & sel_cmd & wr_cmd.start;
  // a launch still in flight counts as busy too
  assign refused   = start_req & (busy | launch_q);
  assign start_ok  = start_req & ~refused;
  assign status_rd = acc & ~pwrite & sel_status;

  assign pready  = 1'b1;
  assign pslverr = acc & ((~sel_cmd & ~sel_status) | refused);

  always_comb begin
    prdata = '0;
    if (acc && !pwrite) begin
      if (sel_cmd) begin
        prdata[2:0] = cmd_q;
      end else if (sel_status) begin
        prdata[ntt_ctrl_pkg::STAT_BUSY]    = busy;
        // a done arriving this cycle is reported already
        prdata[ntt_ctrl_pkg::STAT_DONE]    = done_q | run_done;
        prdata[ntt_ctrl_pkg::STAT_SCHEME]  = cmd_q.scheme;
        prdata[ntt_ctrl_pkg::STAT_INVERSE] = cmd_q.inverse;
      end
    end
  end

  // command held from the last accepted start
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      cmd_q    <= '0;
      launch_q <= 1'b0;
    end else begin
      launch_q <= start_ok;
      if (start_ok) begin
        cmd_q <= wr_cmd;
      end
    end
  end

  // busy from launch to run_done, launch wins a tie
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      busy_q <= 1'b0;
    end else if (launch_q) begin
      busy_q <= 1'b1;
    end else if (run_done) begin
      busy_q <= 1'b0;
    end
  end

  // sticky done, cleared by a status read
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      done_q <= 1'b0;
    end else if (status_rd) begin
      done_q <= 1'b0;
    end else if (run_done) begin
      done_q <= 1'b1;
    end
  end

  // busy drops together with the done pulse
  assign busy   = busy_q & ~run_done;
  assign launch = launch_q;
  assign cmd    = cmd_q;

endmodule

`default_nettype wire

/* hw/ntt_ctrl_pkg.sv */
`default_nettype none

package ntt_ctrl_pkg;

  // transform family selected by the host
  typedef enum logic {
    SCHEME_KYBER = 1'b0,
    SCHEME_DIL   = 1'b1
  } ntt_scheme_t;

  // command word as written to ADDR_CMD
  // bit 0 start, bit 1 inverse, bit 2 scheme
  typedef struct packed {
    ntt_scheme_t scheme;
    logic        inverse;
    logic        start;
  } ntt_cmd_t;

  // one butterfly index per clock
  typedef struct packed {
    // stage
    logic [2:0] p;
    // group inside the stage
    logic [6:0] k;
    // offset inside the group
    logic [6:0] j;
    // final index of the final stage
    logic       last;
  } ntt_index_t;

  // apb widths
  typedef logic [3:0]  apb_addr_t;
  typedef logic [31:0] apb_data_t;

  // kyber radix-4, 32 butterflies per stage
  localparam int unsigned KYBER_LEN    = 32;
  localparam int unsigned KYBER_STAGES = 3;

  // dilithium radix-2, 128 butterflies per stage
  localparam int unsigned DIL_LEN    = 128;
  localparam int unsigned DIL_STAGES = 8;

  // register map
  localparam apb_addr_t ADDR_CMD    = 4'h0;
  localparam apb_addr_t ADDR_STATUS = 4'h4;

  // status register bit positions
  localparam int unsigned STAT_BUSY    = 0;
  localparam int unsigned STAT_DONE    = 1;
  localparam int unsigned STAT_SCHEME  = 2;
  localparam int unsigned STAT_INVERSE = 3;

endpackage

`default_nettype wire

/* hw/ntt_ctrl_top.sv */
`timescale 1ns/1ns
`default_nettype none

module ntt_ctrl_top #(
  // radix-2 latencies in cycles after ren
  parameter int unsigned BF_LAT_R2 = 10,
  parameter int unsigned WB_LAT_R2 = 11,
  // radix-4 latencies in cycles after ren
  parameter int unsigned BF_LAT_R4 = 12,
  parameter int unsigned WB_LAT_R4 = 13
) (
  input  wire                      clk,
  input  wire                      rst,
  input  wire                      psel,
  input  wire                      penable,
  input  wire                      pwrite,
  input  ntt_ctrl_pkg::apb_addr_t   paddr,
  input  ntt_ctrl_pkg::apb_data_t   pwdata,
  output ntt_ctrl_pkg::apb_data_t   prdata,
  output logic                     pready,
  output logic                     pslverr,
  output ntt_ctrl_pkg::ntt_index_t  idx,
  output logic                     ren,
  output logic                     bf_en,
  output logic                     wen,
  output logic                     radix4,
  output logic                     inverse,
  output logic                     done_irq
);

  ntt_ctrl_pkg::ntt_cmd_t cmd;
  logic                   launch;
  logic                   run_done;

  // host registers and run launch
  ntt_apb_regs ntt_apb_regs_i (
    .clk      (clk),
    .rst      (rst),
    .psel     (psel),
    .penable  (penable),
    .pwrite   (pwrite),
    .paddr    (paddr),
    .pwdata   (pwdata),
    .run_done (run_done),
    .prdata   (prdata),
    .pready   (pready),
    .pslverr  (pslverr),
    .launch   (launch),
    .cmd      (cmd),
    .busy     ()
  );

  // butterfly index sequence
  ntt_loop_gen ntt_loop_gen_i (
    .clk    (clk),
    .rst    (rst),
    .launch (launch),
    .cmd    (cmd),
    .idx    (idx),
    .ren    (ren),
    .radix4 (radix4)
  );

  // pipeline latency and completion
  ntt_writeback_delay #(
    .BF_LAT_R2 (BF_LAT_R2),
    .WB_LAT_R2 (WB_LAT_R2),
    .BF_LAT_R4 (BF_LAT_R4),
    .WB_LAT_R4 (WB_LAT_R4)
  ) ntt_writeback_delay_i (
    .clk      (clk),
    .rst      (rst),
    .ren      (ren),
    .last     (idx.last),
    .radix4   (radix4),
    .bf_en    (bf_en),
    .wen      (wen),
    .run_done (run_done)
  );

  // command only changes on an accepted start
  assign inverse = cmd.inverse;
  // one pulse per completed run
  assign done_irq = run_done;

endmodule

`default_nettype wire

/* hw/ntt_loop_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module ntt_loop_gen (
  input  wire                    clk,
  input  wire                    rst,
  input  wire                    launch,
  input  ntt_ctrl_pkg::ntt_cmd_t  cmd,
  output ntt_ctrl_pkg::ntt_index_t idx,
  output logic                   ren,
  output logic                   radix4
);

  logic [2:0] p_q;
  logic [6:0] k_q;
  logic [6:0] j_q;
  logic       ren_q;
  logic       radix4_q;
  logic       inverse_q;

  logic [2:0] shift;
  logic [7:0] len;
  logic [7:0] span;
  logic [6:0] j_max;
  logic [6:0] k_max;
  logic [2:0] top_stage;
  logic [2:0] end_stage;
  logic [2:0] first_stage;
  logic       j_wrap;
  logic       k_wrap;
  logic       last;

  // span exponent, 2p for radix-4 and p for radix-2
  assign shift = radix4_q ? {p_q[1:0], 1'b0} : p_q;
  assign len   = radix4_q ? 8'(ntt_ctrl_pkg::KYBER_LEN) : 8'(ntt_ctrl_pkg::DIL_LEN);
  assign span  = 8'd1 << shift;

  // j runs inside one group, k over the groups of a stage
  assign j_max = 7'(span - 8'd1);
  assign k_max = 7'((len >> shift) - 8'd1);

  assign top_stage = radix4_q ? 3'(ntt_ctrl_pkg::KYBER_STAGES - 1)
                              : 3'(ntt_ctrl_pkg::DIL_STAGES - 1);
  // forward ends at stage 0, inverse at the top stage
  assign end_stage = inverse_q ? top_stage : 3'd0;

  assign j_wrap = (j_q == j_max);
  assign k_wrap = (k_q == k_max);
  assign last   = ren_q & j_wrap & k_wrap & (p_q == end_stage);

  // start stage taken straight from the new command
  always_comb begin
    if (cmd.inverse) begin
      first_stage = 3'd0;
    end else if (cmd.scheme == ntt_ctrl_pkg::SCHEME_KYBER) begin
      first_stage = 3'(ntt_ctrl_pkg::KYBER_STAGES - 1);
    end else begin
      first_stage = 3'(ntt_ctrl_pkg::DIL_STAGES - 1);
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      ren_q     <= 1'b0;
      radix4_q  <= 1'b0;
      inverse_q <= 1'b0;
      p_q       <= '0;
      k_q       <= '0;
      j_q       <= '0;
    end else if (launch) begin
      // first index appears on the edge after launch
      ren_q     <= 1'b1;
      radix4_q  <= (cmd.scheme == ntt_ctrl_pkg::SCHEME_KYBER);
      inverse_q <= cmd.inverse;
      p_q       <= first_stage;
      k_q       <= '0;
      j_q       <= '0;
    end else if (ren_q) begin
      if (last) begin
        // run finished, park the index at zero
        ren_q <= 1'b0;
        p_q   <= '0;
        k_q   <= '0;
        j_q   <= '0;
      end else if (j_wrap) begin
        j_q <= '0;
        if (k_wrap) begin
          k_q <= '0;
          // next stage in the direction of the transform
          if (inverse_q) begin
            p_q <= p_q + 3'd1;
          end else begin
            p_q <= p_q - 3'd1;
          end
        end else begin
          k_q <= k_q + 7'd1;
        end
      end else begin
        j_q <= j_q + 7'd1;
      end
    end
  end

  assign idx.p    = p_q;
  assign idx.k    = k_q;
  assign idx.j    = j_q;
  assign idx.last = last;
  assign ren      = ren_q;
  assign radix4   = radix4_q;

endmodule

`default_nettype wire

/* hw/ntt_writeback_delay.sv */
`timescale 1ns/1ns
`default_nettype none

module ntt_writeback_delay #(
  parameter int unsigned BF_LAT_R2 = 10,
  parameter int unsigned WB_LAT_R2 = 11,
  parameter int unsigned BF_LAT_R4 = 12,
  parameter int unsigned WB_LAT_R4 = 13
) (
  input  wire  clk,
  input  wire  rst,
  input  wire  ren,
  input  wire  last,
  input  wire  radix4,
  output logic bf_en,
  output logic wen,
  output logic run_done
);

  // chain deep enough for the slower write-back
  localparam int unsigned MAX_LAT = (WB_LAT_R2 > WB_LAT_R4) ? WB_LAT_R2 : WB_LAT_R4;

  // ren and last move together through the pipeline
  typedef struct packed {
    logic ren;
    logic last;
  } slot_t;

  slot_t [MAX_LAT-1:0] chain;
  slot_t               bf_tap;
  slot_t               wb_tap;
  logic                radix_q;
  logic                run_start;
  logic                done_q;

  // entry i is ren delayed by i+1 cycles
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      chain <= '0;
    end else begin
      chain <= {chain[MAX_LAT-2:0], slot_t'{ren: ren, last: last}};
    end
  end

  // rising edge of ren marks a new run
  assign run_start = ren & ~chain[0].ren;

  // radix stays fixed for the whole run
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      radix_q <= 1'b0;
    end else if (run_start) begin
      radix_q <= radix4;
    end
  end

  // taps at the latencies of the active radix
  assign bf_tap = radix_q ? chain[BF_LAT_R4-1] : chain[BF_LAT_R2-1];
  assign wb_tap = radix_q ? chain[WB_LAT_R4-1] : chain[WB_LAT_R2-1];

  assign bf_en = bf_tap.ren;
  assign wen   = wb_tap.ren;

  // last write-back has left, done one cycle later
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      done_q <= 1'b0;
    end else begin
      done_q <= wb_tap.ren & wb_tap.last;
    end
  end

  assign run_done = done_q;

endmodule

`default_nettype wire

/* ntt_ctrl_top.f */
hw/ntt_ctrl_pkg.sv
hw/ntt_apb_regs.sv
hw/ntt_loop_gen.sv
hw/ntt_writeback_delay.sv
hw/ntt_ctrl_top.sv
tb/ntt_ctrl_checker.sv
tb/ntt_ctrl_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the NTT sequencer testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module ntt_ctrl_tb \
  -f ntt_ctrl_top.f -o ntt_ctrl_sim \
  && ./obj_dir/ntt_ctrl_sim > sim.log 2>&1 \
  || echo "build or simulation did not complete"
cat sim.log 2>/dev/null
grep -q "=== PASS ===" sim.log 2>/dev/null \
  && echo "simulation passed" \
  && exit 0 \
  || { echo "simulation failed"; exit 1; }

/* tb/ntt_ctrl_checker.sv */
`timescale 1ns/1ns
`default_nettype none

module ntt_ctrl_checker #(
  parameter int unsigned BF_LAT_R2 = 10,
  parameter int unsigned WB_LAT_R2 = 11,
  parameter int unsigned BF_LAT_R4 = 12,
  parameter int unsigned WB_LAT_R4 = 13
) (
  input  wire                      clk,
  input  wire                      rst,
  input  wire                      psel,
  input  wire                      penable,
  input  wire                      pwrite,
  input  ntt_ctrl_pkg::apb_addr_t   paddr,
  input  ntt_ctrl_pkg::apb_data_t   pwdata,
  input  ntt_ctrl_pkg::apb_data_t   prdata,
  input  wire                      pready,
  input  wire                      pslverr,
  input  ntt_ctrl_pkg::ntt_index_t  idx,
  input  wire                      ren,
  input  wire                      bf_en,
  input  wire                      wen,
  input  wire                      radix4,
  input  wire                      inverse,
  input  wire                      done_irq,
  output int                       err_count,
  output int                       idx_count,
  output int                       run_count
);

  // deeper than any write-back latency plus one
  localparam int HIST = 32;

  ntt_ctrl_pkg::ntt_index_t exp_q[$];
  ntt_ctrl_pkg::ntt_index_t exp_idx;
  ntt_ctrl_pkg::apb_data_t  exp_rd;
  logic [HIST-1:0]          ren_h;
  logic [HIST-1:0]          last_h;
  int                       lead;
  int                       bl;
  int                       wl;
  int                       errs = 0;
  int                       idxs = 0;
  int                       runs = 0;
  bit                       run_active;
  bit                       model_radix4;
  bit                       pend_radix4;
  bit                       sticky_done;
  bit                       last_scheme;
  bit                       last_inv;
  bit                       exp_ren;
  bit                       exp_last;
  bit                       exp_done;
  bit                       exp_err;
  bit                       acc;
  bit                       start_wr;
  bit                       status_rd;
  bit                       unmapped;

  assign err_count = errs;
  assign idx_count = idxs;
  assign run_count = runs;

  task automatic flag_error(input string msg);
    errs++;
    $display("FAILED %0t: %s", $time, msg);
  endtask

  // nested loops straight from the transform definition
  task automatic build_run(input bit dil, input bit inv);
    ntt_ctrl_pkg::ntt_index_t ent;
    int nst;
    int len;
    int p;
    int span;
    nst = dil ? ntt_ctrl_pkg::DIL_STAGES : ntt_ctrl_pkg::KYBER_STAGES;
    len = dil ? ntt_ctrl_pkg::DIL_LEN : ntt_ctrl_pkg::KYBER_LEN;
    exp_q.delete();
    for (int s = 0; s < nst; s++) begin
      p = inv ? s : nst - 1 - s;
      // 2^p for radix-2, 4^p for radix-4
      span = dil ? (1 << p) : (1 << (2 * p));
      for (int k = 0; k < len / span; k++) begin
        for (int j = 0; j < span; j++) begin
          ent.p    = 3'(p);
          ent.k    = 7'(k);
          ent.j    = 7'(j);
          ent.last = 1'b0;
          exp_q.push_back(ent);
        end
      end
    end
  endtask

  // sample mid cycle, all outputs settled
  always @(negedge clk) begin
    if (rst) begin
      exp_q.delete();
      ren_h        = '0;
      last_h       = '0;
      lead         = 0;
      run_active   = 0;
      model_radix4 = 0;
      pend_radix4  = 0;
      sticky_done  = 0;
      last_scheme  = 0;
      last_inv     = 0;
      if (ren || bf_en || wen || done_irq || pslverr) begin
        flag_error("control output high during reset");
      end
    end else begin
      // two cycles from accepted write to first index
      if (lead > 0) begin
        lead = lead - 1;
        if (lead == 0) begin
          model_radix4 = pend_radix4;
        end
      end
      exp_ren  = 0;
      exp_last = 0;
      if (lead == 0 && exp_q.size() > 0) begin
        exp_idx  = exp_q.pop_front();
        exp_ren  = 1;
        exp_last = (exp_q.size() == 0);
      end
      // bit d holds the expected ren of d cycles ago
      ren_h  = {ren_h[HIST-2:0], exp_ren};
      last_h = {last_h[HIST-2:0], exp_last};
      bl = model_radix4 ? BF_LAT_R4 : BF_LAT_R2;
      wl = model_radix4 ? WB_LAT_R4 : WB_LAT_R2;
      exp_done = last_h[wl+1];

      if (ren !== exp_ren) begin
        flag_error($sformatf("ren %0b, expected %0b", ren, exp_ren));
      end
      if (exp_ren) begin
        idxs++;
        if (idx.p !== exp_idx.p || idx.k !== exp_idx.k || idx.j !== exp_idx.j) begin
          flag_error($sformatf("index p/k/j %0d/%0d/%0d, expected %0d/%0d/%0d",
                               idx.p, idx.k, idx.j, exp_idx.p, exp_idx.k, exp_idx.j));
        end
      end
      if (idx.last !== exp_last) begin
        flag_error($sformatf("last flag %0b, expected %0b", idx.last, exp_last));
      end
      if (bf_en !== ren_h[bl]) begin
        flag_error($sformatf("bf_en %0b, expected %0b", bf_en, ren_h[bl]));
      end
      if (wen !== ren_h[wl]) begin
        flag_error($sformatf("wen %0b, expected %0b", wen, ren_h[wl]));
      end
      if (done_irq !== exp_done) begin
        flag_error($sformatf("done_irq %0b, expected %0b", done_irq, exp_done));
      end
      if (radix4 !== model_radix4 || inverse !== last_inv) begin
        flag_error($sformatf("radix4/inverse %0b/%0b, expected %0b/%0b",
                             radix4, inverse, model_radix4, last_inv));
      end
      if (pready !== 1'b1) begin
        flag_error("pready low");
      end

      // apb side, done frees the sequencer in its own cycle
      if (exp_done) begin
        run_active = 0;
      end
      acc       = psel && penable;
      unmapped  = (paddr != ntt_ctrl_pkg::ADDR_CMD) && (paddr != ntt_ctrl_pkg::ADDR_STATUS);
      start_wr  = acc && pwrite && (paddr == ntt_ctrl_pkg::ADDR_CMD) && pwdata[0];
      status_rd = acc && !pwrite && (paddr == ntt_ctrl_pkg::ADDR_STATUS);
      exp_err   = acc && (unmapped || (start_wr && run_active));
      if (pslverr !== exp_err) begin
        flag_error($sformatf("pslverr %0b, expected %0b, paddr %0h", pslverr, exp_err, paddr));
      end
      if (status_rd) begin
        exp_rd    = '0;
        // busy shows once the first index is out
        exp_rd[0] = run_active && (lead == 0);
        exp_rd[1] = sticky_done || exp_done;
        exp_rd[2] = last_scheme;
        exp_rd[3] = last_inv;
        if (prdata !== exp_rd) begin
          flag_error($sformatf("status %0h, expected %0h", prdata, exp_rd));
        end
      end

      // state for the next cycle
      if (status_rd) begin
        sticky_done = 0;
      end else if (exp_done) begin
        sticky_done = 1;
      end
      if (exp_done) begin
        last_h = '0;
        runs++;
      end
      if (start_wr && !exp_err) begin
        last_scheme = pwdata[2];
        last_inv    = pwdata[1];
        pend_radix4 = !pwdata[2];
        build_run(pwdata[2], pwdata[1]);
        lead       = 2;
        run_active = 1;
      end
    end
  end

endmodule

`default_nettype wire

/* tb/ntt_ctrl_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module ntt_ctrl_tb;

  localparam int unsigned BF_LAT_R2 = 10;
  localparam int unsigned WB_LAT_R2 = 11;
  localparam int unsigned BF_LAT_R4 = 12;
  localparam int unsigned WB_LAT_R4 = 13;
  localparam int          NUM_RUNS  = 12;
  // longest run plus pipeline and margin
  localparam int          DONE_LIMIT = 1400;

  logic                     clk;
  logic                     rst;
  logic                     psel;
  logic                     penable;
  logic                     pwrite;
  ntt_ctrl_pkg::apb_addr_t  paddr;
  ntt_ctrl_pkg::apb_data_t  pwdata;
  ntt_ctrl_pkg::apb_data_t  prdata;
  logic                     pready;
  logic                     pslverr;
  ntt_ctrl_pkg::ntt_index_t idx;
  logic                     ren;
  logic                     bf_en;
  logic                     wen;
  logic                     radix4;
  logic                     inverse;
  logic                     done_irq;

  int                       err_count;
  int                       idx_count;
  int                       run_count;
  int                       timeouts;
  int                       seed_val;
  bit                       dil;
  bit                       inv;
  ntt_ctrl_pkg::apb_data_t  wdata;

  always #4 clk = ~clk;

  ntt_ctrl_top #(
    .BF_LAT_R2 (BF_LAT_R2),
    .WB_LAT_R2 (WB_LAT_R2),
    .BF_LAT_R4 (BF_LAT_R4),
    .WB_LAT_R4 (WB_LAT_R4)
  ) ntt_ctrl_top_i (
    .clk (clk), .rst (rst), .psel (psel), .penable (penable), .pwrite (pwrite),
    .paddr (paddr), .pwdata (pwdata), .prdata (prdata), .pready (pready),
    .pslverr (pslverr), .idx (idx), .ren (ren), .bf_en (bf_en), .wen (wen),
    .radix4 (radix4), .inverse (inverse), .done_irq (done_irq)
  );

  ntt_ctrl_checker #(
    .BF_LAT_R2 (BF_LAT_R2),
    .WB_LAT_R2 (WB_LAT_R2),
    .BF_LAT_R4 (BF_LAT_R4),
    .WB_LAT_R4 (WB_LAT_R4)
  ) checker_i (
    .clk (clk), .rst (rst), .psel (psel), .penable (penable), .pwrite (pwrite),
    .paddr (paddr), .pwdata (pwdata), .prdata (prdata), .pready (pready),
    .pslverr (pslverr), .idx (idx), .ren (ren), .bf_en (bf_en), .wen (wen),
    .radix4 (radix4), .inverse (inverse), .done_irq (done_irq),
    .err_count (err_count), .idx_count (idx_count), .run_count (run_count)
  );

  // entered and left 1 ns after a rising edge
  task automatic apb_access(input logic wr, input ntt_ctrl_pkg::apb_addr_t addr,
                            input ntt_ctrl_pkg::apb_data_t data);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = data;
    @(posedge clk);
    #1;
    // access phase
    penable = 1'b1;
    @(posedge clk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  // poll done_irq mid cycle up to a limit
  task automatic wait_for_done(input int limit);
    int  n;
    bit  seen;
    n    = 0;
    seen = 0;
    while (!seen && n < limit) begin
      @(negedge clk);
      seen = done_irq;
      n++;
    end
    @(posedge clk);
    #1;
    if (!seen) begin
      timeouts++;
      $display("timeout: done_irq did not pulse within %0d cycles", limit);
    end
  endtask

  // any address outside the two registers
  function automatic ntt_ctrl_pkg::apb_addr_t pick_unmapped();
    ntt_ctrl_pkg::apb_addr_t a;
    a = 4'($urandom_range(1, 14));
    if (a == ntt_ctrl_pkg::ADDR_STATUS) begin
      a = 4'hf;
    end
    return a;
  endfunction

  initial begin
    clk      = 1'b0;
    rst      = 1'b1;
    psel     = 1'b0;
    penable  = 1'b0;
    pwrite   = 1'b0;
    paddr    = '0;
    pwdata   = '0;
    timeouts = 0;
    seed_val = $urandom(70802);
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b0;
    // quiet outputs and a clean status before any command
    idle_cycles(5);
    apb_access(1'b0, ntt_ctrl_pkg::ADDR_STATUS, '0);

    for (int run = 0; run < NUM_RUNS; run++) begin
      // first four runs cover every scheme and direction
      if (run < 4) begin
        dil = run[1];
        inv = run[0];
      end else begin
        dil = 1'($urandom_range(0, 1));
        inv = 1'($urandom_range(0, 1));
      end
      wdata      = $urandom();
      wdata[2:0] = {dil, inv, 1'b1};
      apb_access(1'b1, ntt_ctrl_pkg::ADDR_CMD, wdata);
      idle_cycles($urandom_range(0, 4));
      apb_access(1'b0, ntt_ctrl_pkg::ADDR_STATUS, '0);
      // start while busy is refused
      if ($urandom_range(0, 1) == 1) begin
        wdata    = $urandom();
        wdata[0] = 1'b1;
        apb_access(1'b1, ntt_ctrl_pkg::ADDR_CMD, wdata);
      end
      if ($urandom_range(0, 1) == 1) begin
        apb_access(1'($urandom_range(0, 1)), pick_unmapped(), $urandom());
      end
      wait_for_done(DONE_LIMIT);
      // sometimes leave done sticky across the next launch
      if ($urandom_range(0, 3) != 0) begin
        apb_access(1'b0, ntt_ctrl_pkg::ADDR_STATUS, '0);
        apb_access(1'b0, ntt_ctrl_pkg::ADDR_STATUS, '0);
      end
    end

    idle_cycles(20);
    apb_access(1'b0, ntt_ctrl_pkg::ADDR_STATUS, '0);
    $display("errors %0d, timeouts %0d, indices checked %0d, runs done %0d",
             err_count, timeouts, idx_count, run_count);
    if (err_count == 0 && timeouts == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire
